//--- project.f
+incdir+.
pipe_pkg.sv
data_ram.sv
mem_stage.sv
wb_unit.sv
wb_stage.sv
regfile.sv
commit_tracker.sv
backend_top.sv
tb_clock.sv
backend_sva.sv
tb_backend.sv

//--- tb_backend.sv
// ==========================================================
// Back end testbench
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

module tb_backend
  import pipe_pkg::*;
;

  localparam int WAIT_LIMIT = 50;

  logic       clk;
  logic       rst;
  logic       i_ex_req;
  xlen_t      i_ex_pc;
  inst_t      i_ex_inst;
  ridx_t      i_ex_rd;
  logic       i_ex_rd_wen;
  xlen_t      i_ex_result;
  logic       i_ex_mem_ren;
  logic       i_ex_mem_wen;
  xlen_t      i_ex_store_data;
  logic       i_ex_nocmt;
  logic       i_ex_skipcmt;
  ridx_t      i_rs_addr;
  logic       o_ex_ack;
  xlen_t      o_rs_data;
  logic       o_commit_valid;
  xlen_t      o_commit_pc;
  inst_t      o_commit_inst;
  logic       o_commit_nocmt;
  logic       o_commit_skipcmt;
  cnt_t       o_instret;
  cnt_t       o_skipped;

  int         seed = 32'h0362_3c75;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  logic       timed_out = 1'b0;
  xlen_t      next_pc = 64'h8000_0000;
  xlen_t      reg_model [0:31];
  xlen_t      mem_model [0:255];
  cnt_t       exp_instret = '0;
  cnt_t       exp_skipped = '0;

  tb_clock u_clock (.o_clk(clk), .o_rst(rst));

  backend_top DUT (.*);

  bind backend_top backend_sva u_sva (
    .clk              (clk),
    .rst              (rst),
    .i_ex_req         (i_ex_req),
    .i_ex_ack         (o_ex_ack),
    .i_ex_mem_ren     (i_ex_mem_ren),
    .i_ex_pc          (i_ex_pc),
    .i_ex_inst        (i_ex_inst),
    .i_commit_valid   (o_commit_valid),
    .i_commit_pc      (o_commit_pc),
    .i_commit_inst    (o_commit_inst),
    .i_commit_nocmt   (o_commit_nocmt),
    .i_commit_skipcmt (o_commit_skipcmt)
  );

  task automatic report_timeout(input string what);
    $display("ERROR at %0t: timed out waiting for %s", $time, what);
    timed_out = 1'b1;
    errors++;
  endtask

  task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
    if (!timed_out) begin
      assert (actual === expected) else begin
        $display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        errors++;
      end
    end
  endtask

  task automatic read_reg_check(input ridx_t idx);
    @(posedge clk);
    i_rs_addr <= idx;
    @(negedge clk);
    check_value($sformatf("o_rs_data(x%0d)", idx), reg_model[idx], o_rs_data);
  endtask

  // Sends one item, waits for its commit and updates the reference model.
  task automatic run_item(input ridx_t rd, input logic rd_wen, input xlen_t result,
                          input logic ren, input logic wen, input xlen_t sdata,
                          input logic nocmt, input logic skipcmt);
    int         cycles;
    xlen_t      pc;
    inst_t      inst;
    dmem_addr_t addr;
    if (timed_out) return;
    pc = next_pc;
    next_pc = next_pc + 4;
    inst = $random(seed);
    addr = dmem_addr_t'(result >> 3);
    cycles = 0;
    @(negedge clk);
    while (!o_ex_ack && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!o_ex_ack) begin
      report_timeout("o_ex_ack");
      return;
    end
    @(posedge clk);
    i_ex_req        <= 1'b1;
    i_ex_pc         <= pc;
    i_ex_inst       <= inst;
    i_ex_rd         <= rd;
    i_ex_rd_wen     <= rd_wen;
    i_ex_result     <= result;
    i_ex_mem_ren    <= ren;
    i_ex_mem_wen    <= wen;
    i_ex_store_data <= sdata;
    i_ex_nocmt      <= nocmt;
    i_ex_skipcmt    <= skipcmt;
    @(posedge clk);  // Ack is still high, so the item is taken here.
    i_ex_req <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!o_commit_valid && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!o_commit_valid) begin
      report_timeout("o_commit_valid");
      return;
    end
    check_value("o_commit_pc", pc, o_commit_pc);
    check_value("o_commit_inst", xlen_t'(inst), xlen_t'(o_commit_inst));
    check_value("o_commit_nocmt", xlen_t'(nocmt), xlen_t'(o_commit_nocmt));
    check_value("o_commit_skipcmt", xlen_t'(skipcmt), xlen_t'(o_commit_skipcmt));
    if (rd_wen && rd != '0) begin
      reg_model[rd] = ren ? mem_model[addr] : result;
    end
    if (wen) begin
      mem_model[addr] = sdata;
    end
    if (!nocmt) begin
      exp_instret++;
      if (skipcmt) exp_skipped++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin : stimulus
    int         e;
    int         i;
    int         cycles;
    int         sva_errors;
    ridx_t      rd;
    xlen_t      data;
    dmem_addr_t addr;
    i_ex_req        <= 1'b0;
    i_ex_pc         <= '0;
    i_ex_inst       <= '0;
    i_ex_rd         <= '0;
    i_ex_rd_wen     <= 1'b0;
    i_ex_result     <= '0;
    i_ex_mem_ren    <= 1'b0;
    i_ex_mem_wen    <= 1'b0;
    i_ex_store_data <= '0;
    i_ex_nocmt      <= 1'b0;
    i_ex_skipcmt    <= 1'b0;
    i_rs_addr       <= '0;
    for (i = 0; i < 32; i++) reg_model[i] = '0;
    cycles = 0;
    @(posedge clk);
    while (rst && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (rst) report_timeout("reset release");
    @(negedge clk);

    e = errors;
    check_value("o_ex_ack", 1, xlen_t'(o_ex_ack));
    check_value("o_commit_valid", 0, xlen_t'(o_commit_valid));
    check_value("o_commit_pc", 0, o_commit_pc);
    check_value("o_commit_inst", 0, xlen_t'(o_commit_inst));
    check_value("o_commit_nocmt", 0, xlen_t'(o_commit_nocmt));
    check_value("o_commit_skipcmt", 0, xlen_t'(o_commit_skipcmt));
    check_value("o_instret", 0, o_instret);
    check_value("o_skipped", 0, o_skipped);
    for (i = 0; i < 32; i++) read_reg_check(ridx_t'(i));
    finish_test("reset", e);

    e = errors;
    for (i = 0; i < 12; i++) begin
      rd = (i % 4 == 3) ? '0 : ridx_t'($random(seed));  // Every fourth write targets x0.
      data = {$random(seed), $random(seed)};
      run_item(rd, 1'b1, data, 1'b0, 1'b0, '0, 1'b0, 1'b0);
      read_reg_check(rd);
    end
    read_reg_check('0);
    finish_test("alu_write", e);

    e = errors;
    for (i = 0; i < 5; i++) begin
      addr = dmem_addr_t'($random(seed));
      data = {$random(seed), $random(seed)};
      rd = ridx_t'($random(seed));
      if (rd == '0) rd = 5'd1;
      run_item('0, 1'b0, xlen_t'(addr) << 3, 1'b0, 1'b1, data, 1'b0, 1'b0);
      run_item(rd, 1'b1, xlen_t'(addr) << 3, 1'b1, 1'b0, '0, 1'b0, 1'b0);
      read_reg_check(rd);
    end
    finish_test("store_load", e);

    e = errors;
    for (i = 0; i < 20; i++) begin
      rd = ridx_t'($random(seed));
      data = {$random(seed), $random(seed)};
      run_item(rd, 1'($random(seed)), data, 1'b0, 1'b0, '0,
               1'($random(seed)), 1'($random(seed)));
      read_reg_check(rd);
    end
    check_value("o_instret", exp_instret, o_instret);
    check_value("o_skipped", exp_skipped, o_skipped);
    finish_test("commit_count", e);

    @(negedge clk);
    sva_errors = DUT.u_sva.fail_count;
    $display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_failed, errors, sva_errors);
    if (errors == 0 && sva_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- backend_sva.sv
// ==========================================================
// Back end protocol assertions
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

module backend_sva
  import pipe_pkg::*;
(
  input wire        clk,
  input wire        rst,
  input wire        i_ex_req,
  input wire        i_ex_ack,
  input wire        i_ex_mem_ren,
  input wire xlen_t i_ex_pc,
  input wire inst_t i_ex_inst,
  input wire        i_commit_valid,
  input wire xlen_t i_commit_pc,
  input wire inst_t i_commit_inst,
  input wire        i_commit_nocmt,
  input wire        i_commit_skipcmt
);

  int unsigned fail_count = 0;
  logic        ex_hs;

  assign ex_hs = i_ex_req & i_ex_ack;

  // ALU and store items commit two cycles after acceptance, loads three.
  assert property (@(posedge clk) disable iff (rst)
    (ex_hs && !i_ex_mem_ren) |-> ##2 (i_commit_valid && i_commit_pc == $past(i_ex_pc, 2)
      && i_commit_inst == $past(i_ex_inst, 2)))
    else begin
      $error("ALU or store item did not commit two cycles after acceptance");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
    (ex_hs && i_ex_mem_ren) |-> ##3 (i_commit_valid && i_commit_pc == $past(i_ex_pc, 3)
      && i_commit_inst == $past(i_ex_inst, 3)))
    else begin
      $error("load item did not commit three cycles after acceptance");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) i_commit_valid |=> !i_commit_valid)
    else begin
      $error("commit valid held high for two cycles in a row");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
    !i_commit_valid |-> (i_commit_pc == '0 && i_commit_inst == '0
      && !i_commit_nocmt && !i_commit_skipcmt))
    else begin
      $error("commit fields not zero while commit valid is low");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (rst) ex_hs |=> !i_ex_ack)
    else begin
      $error("execute ack still high in the cycle after an acceptance");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- tb_clock.sv
// ==========================================================
// Testbench clock and reset
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;  // 4 ns period.
  end

  initial begin
    o_rst = 1'b1;
    repeat (16) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- backend_top.sv
// ==========================================================
// Back end top level
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

module backend_top
  import pipe_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        i_ex_req,
  input  wire xlen_t i_ex_pc,
  input  wire inst_t i_ex_inst,
  input  wire ridx_t i_ex_rd,
  input  wire        i_ex_rd_wen,
  input  wire xlen_t i_ex_result,
  input  wire        i_ex_mem_ren,
  input  wire        i_ex_mem_wen,
  input  wire xlen_t i_ex_store_data,
  input  wire        i_ex_nocmt,
  input  wire        i_ex_skipcmt,
  output logic       o_ex_ack,
  input  wire ridx_t i_rs_addr,
  output xlen_t      o_rs_data,
  output logic       o_commit_valid,
  output xlen_t      o_commit_pc,
  output inst_t      o_commit_inst,
  output logic       o_commit_nocmt,
  output logic       o_commit_skipcmt,
  output cnt_t       o_instret,
  output cnt_t       o_skipped
);

  logic       ram_en;
  logic       ram_we;
  dmem_addr_t ram_addr;
  xlen_t      ram_wdata;
  xlen_t      ram_rdata;
  logic       mem_req;
  xlen_t      mem_pc;
  inst_t      mem_inst;
  ridx_t      mem_rd;
  logic       mem_rd_wen;
  xlen_t      mem_rd_wdata;
  logic       mem_nocmt;
  logic       mem_skipcmt;
  logic       wb_req;
  logic       wb_ack;
  logic       rf_we;
  ridx_t      rf_waddr;
  xlen_t      rf_wdata;

  mem_stage u_mem_stage (
    .clk             (clk),
    .rst             (rst),
    .i_ex_req        (i_ex_req),
    .i_ex_pc         (i_ex_pc),
    .i_ex_inst       (i_ex_inst),
    .i_ex_rd         (i_ex_rd),
    .i_ex_rd_wen     (i_ex_rd_wen),
    .i_ex_result     (i_ex_result),
    .i_ex_mem_ren    (i_ex_mem_ren),
    .i_ex_mem_wen    (i_ex_mem_wen),
    .i_ex_store_data (i_ex_store_data),
    .i_ex_nocmt      (i_ex_nocmt),
    .i_ex_skipcmt    (i_ex_skipcmt),
    .o_ex_ack        (o_ex_ack),
    .o_ram_en        (ram_en),
    .o_ram_we        (ram_we),
    .o_ram_addr      (ram_addr),
    .o_ram_wdata     (ram_wdata),
    .i_ram_rdata     (ram_rdata),
    .o_mem_req       (mem_req),
    .o_mem_pc        (mem_pc),
    .o_mem_inst      (mem_inst),
    .o_mem_rd        (mem_rd),
    .o_mem_rd_wen    (mem_rd_wen),
    .o_mem_rd_wdata  (mem_rd_wdata),
    .o_mem_nocmt     (mem_nocmt),
    .o_mem_skipcmt   (mem_skipcmt)
  );

  data_ram u_data_ram (
    .clk     (clk),
    .i_en    (ram_en),
    .i_we    (ram_we),
    .i_addr  (ram_addr),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

  wb_stage u_wb_stage (
    .clk                  (clk),
    .rst                  (rst),
    .i_wb_memoryed_req    (mem_req),
    .o_wb_writebacked_req (wb_req),
    .i_wb_writebacked_ack (wb_ack),
    .i_wb_pc              (mem_pc),
    .i_wb_inst            (mem_inst),
    .i_wb_rd              (mem_rd),
    .i_wb_rd_wen          (mem_rd_wen),
    .i_wb_rd_wdata        (mem_rd_wdata),
    .i_wb_nocmt           (mem_nocmt),
    .i_wb_skipcmt         (mem_skipcmt),
    .o_wb_pc              (o_commit_pc),
    .o_wb_inst            (o_commit_inst),
    .o_wb_nocmt           (o_commit_nocmt),
    .o_wb_skipcmt         (o_commit_skipcmt),
    .o_rf_we              (rf_we),
    .o_rf_waddr           (rf_waddr),
    .o_rf_wdata           (rf_wdata)
  );

  regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .i_we    (rf_we),
    .i_waddr (rf_waddr),
    .i_wdata (rf_wdata),
    .i_raddr (i_rs_addr),
    .o_rdata (o_rs_data)
  );

  commit_tracker u_commit_tracker (
    .clk       (clk),
    .rst       (rst),
    .i_wb_req  (wb_req),
    .i_nocmt   (o_commit_nocmt),
    .i_skipcmt (o_commit_skipcmt),
    .o_wb_ack  (wb_ack),
    .o_instret (o_instret),
    .o_skipped (o_skipped)
  );

  assign o_commit_valid = wb_req;

endmodule

`default_nettype wire

//--- commit_tracker.sv
// ==========================================================
// Commit tracker
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

module commit_tracker
  import pipe_pkg::*;
(
  input  wire  clk,
  input  wire  rst,
  input  wire  i_wb_req,
  input  wire  i_nocmt,
  input  wire  i_skipcmt,
  output logic o_wb_ack,
  output cnt_t o_instret,
  output cnt_t o_skipped
);

  logic retire;

  assign o_wb_ack = i_wb_req;  // Every commit is taken at once.
  assign retire   = i_wb_req & ~i_nocmt;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_instret <= '0;
      o_skipped <= '0;
    end else if (retire) begin
      o_instret <= o_instret + 1'b1;
      if (i_skipcmt) begin
        o_skipped <= o_skipped + 1'b1;  // Retired but hidden from the reference model.
      end
    end
  end

endmodule

`default_nettype wire

//--- regfile.sv
// ==========================================================
// Integer register file
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

module regfile
  import pipe_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        i_we,
  input  wire ridx_t i_waddr,
  input  wire xlen_t i_wdata,
  input  wire ridx_t i_raddr,
  output xlen_t      o_rdata
);

  xlen_t regs [1:31];  // x0 has no storage.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata = (i_raddr == '0) ? '0 : regs[i_raddr];

endmodule

`default_nettype wire

//--- wb_stage.sv
// ==========================================================
// Writeback stage
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

module wb_stage
  import pipe_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        i_wb_memoryed_req,
  output logic       o_wb_writebacked_req,
  input  wire        i_wb_writebacked_ack,
  input  wire xlen_t i_wb_pc,
  input  wire inst_t i_wb_inst,
  input  wire ridx_t i_wb_rd,
  input  wire        i_wb_rd_wen,
  input  wire xlen_t i_wb_rd_wdata,
  input  wire        i_wb_nocmt,
  input  wire        i_wb_skipcmt,
  output xlen_t      o_wb_pc,
  output inst_t      o_wb_inst,
  output logic       o_wb_nocmt,
  output logic       o_wb_skipcmt,
  output logic       o_rf_we,
  output ridx_t      o_rf_waddr,
  output xlen_t      o_rf_wdata
);

  logic  ena;
  xlen_t hold_pc;
  inst_t hold_inst;
  ridx_t hold_rd;
  logic  hold_rd_wen;
  xlen_t hold_rd_wdata;
  logic  hold_nocmt;
  logic  hold_skipcmt;

  // Every memory request is taken, there is no stall here.
  always_ff @(posedge clk) begin
    if (rst) begin
      ena                  <= 1'b0;
      o_wb_writebacked_req <= 1'b0;
    end else if (i_wb_memoryed_req) begin
      ena                  <= 1'b1;
      o_wb_writebacked_req <= 1'b1;
    end else if (i_wb_writebacked_ack) begin
      ena                  <= 1'b0;
      o_wb_writebacked_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_wb_memoryed_req) begin
      hold_pc       <= i_wb_pc;
      hold_inst     <= i_wb_inst;
      hold_rd       <= i_wb_rd;
      hold_rd_wen   <= i_wb_rd_wen;
      hold_rd_wdata <= i_wb_rd_wdata;
      hold_nocmt    <= i_wb_nocmt;
      hold_skipcmt  <= i_wb_skipcmt;
    end
  end

  assign o_wb_pc      = ena ? hold_pc : '0;  // Commit fields read zero when idle.
  assign o_wb_inst    = ena ? hold_inst : '0;
  assign o_wb_nocmt   = ena & hold_nocmt;
  assign o_wb_skipcmt = ena & hold_skipcmt;

  wb_unit u_wb_unit (
    .clk        (clk),
    .rst        (rst),
    .i_ena      (ena),
    .i_rd       (hold_rd),
    .i_rd_wen   (hold_rd_wen),
    .i_rd_wdata (hold_rd_wdata),
    .o_rd       (o_rf_waddr),
    .o_rd_wen   (o_rf_we),
    .o_rd_wdata (o_rf_wdata)
  );

endmodule

`default_nettype wire

//--- wb_unit.sv
// ==========================================================
// Writeback register write gate
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

module wb_unit
  import pipe_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        i_ena,
  input  wire ridx_t i_rd,
  input  wire        i_rd_wen,
  input  wire xlen_t i_rd_wdata,
  output ridx_t      o_rd,
  output logic       o_rd_wen,
  output xlen_t      o_rd_wdata
);

  logic fire;

  assign fire       = i_ena & i_rd_wen & (i_rd != '0);  // The zero register is never written.
  assign o_rd_wen   = fire;
  assign o_rd       = fire ? i_rd : '0;
  assign o_rd_wdata = fire ? i_rd_wdata : '0;

endmodule

`default_nettype wire

//--- mem_stage.sv
// ==========================================================
// Memory stage
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

`include "pipe_config.svh"

module mem_stage
  import pipe_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             i_ex_req,
  input  wire xlen_t      i_ex_pc,
  input  wire inst_t      i_ex_inst,
  input  wire ridx_t      i_ex_rd,
  input  wire             i_ex_rd_wen,
  input  wire xlen_t      i_ex_result,
  input  wire             i_ex_mem_ren,
  input  wire             i_ex_mem_wen,
  input  wire xlen_t      i_ex_store_data,
  input  wire             i_ex_nocmt,
  input  wire             i_ex_skipcmt,
  output logic            o_ex_ack,
  output logic            o_ram_en,
  output logic            o_ram_we,
  output dmem_addr_t      o_ram_addr,
  output xlen_t           o_ram_wdata,
  input  wire xlen_t      i_ram_rdata,
  output logic            o_mem_req,
  output xlen_t           o_mem_pc,
  output inst_t           o_mem_inst,
  output ridx_t           o_mem_rd,
  output logic            o_mem_rd_wen,
  output xlen_t           o_mem_rd_wdata,
  output logic            o_mem_nocmt,
  output logic            o_mem_skipcmt
);

  mem_state_t state;
  logic       ex_hs;

  assign o_ex_ack = (state == MS_IDLE);
  assign ex_hs    = i_ex_req & o_ex_ack;

  // The RAM access goes out in the same cycle the item is accepted.
  assign o_ram_en    = ex_hs & (i_ex_mem_ren | i_ex_mem_wen);
  assign o_ram_we    = ex_hs & i_ex_mem_wen;
  assign o_ram_addr  = i_ex_result[3 +: `DMEM_AW];  // Aligned doublewords only.
  assign o_ram_wdata = i_ex_store_data;

  assign o_mem_req = (state == MS_SEND);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= MS_IDLE;
    end else begin
      case (state)
        MS_IDLE: begin
          if (ex_hs) begin
            state <= i_ex_mem_ren ? MS_LOAD : MS_SEND;
          end
        end
        MS_LOAD: state <= MS_SEND;  // RAM data is valid in this cycle.
        MS_SEND: state <= MS_IDLE;
        default: state <= MS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ex_hs) begin
      o_mem_pc       <= i_ex_pc;
      o_mem_inst     <= i_ex_inst;
      o_mem_rd       <= i_ex_rd;
      o_mem_rd_wen   <= i_ex_rd_wen;
      o_mem_rd_wdata <= i_ex_result;
      o_mem_nocmt    <= i_ex_nocmt;
      o_mem_skipcmt  <= i_ex_skipcmt;
    end else if (state == MS_LOAD) begin
      o_mem_rd_wdata <= i_ram_rdata;  // Load result replaces the address.
    end
  end

endmodule

`default_nettype wire

//--- data_ram.sv
// ==========================================================
// Data memory
// ==========================================================

`timescale 1ns/1ns
`default_nettype none

`include "pipe_config.svh"

module data_ram
  import pipe_pkg::*;
(
  input  wire             clk,
  input  wire             i_en,
  input  wire             i_we,
  input  wire dmem_addr_t i_addr,
  input  wire xlen_t      i_wdata,
  output xlen_t           o_rdata
);

  xlen_t mem [0:`DMEM_DEPTH-1];

  always_ff @(posedge clk) begin
    if (i_en) begin
      if (i_we) begin
        mem[i_addr] <= i_wdata;
      end
      o_rdata <= mem[i_addr];  // Old contents on a write.
    end
  end

endmodule

`default_nettype wire

//--- pipe_pkg.sv
// ==========================================================
// Back end types
// ==========================================================

`default_nettype none

`include "pipe_config.svh"

package pipe_pkg;

  typedef logic [`XLEN_W-1:0]  xlen_t;       // Data, address or pc word.
  typedef logic [`INST_W-1:0]  inst_t;
  typedef logic [`RIDX_W-1:0]  ridx_t;
  typedef logic [`DMEM_AW-1:0] dmem_addr_t;  // Doubleword index into data memory.
  typedef logic [`CNT_W-1:0]   cnt_t;

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_LOAD,
    MS_SEND
  } mem_state_t;

endpackage

`default_nettype wire

//--- pipe_config.svh
// ==========================================================
// Back end widths and sizes
// ==========================================================

`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Data and pc word.
`define XLEN_W 64

`define INST_W 32
`define RIDX_W 5

// Data memory is addressed in doublewords.
`define DMEM_AW 8
`define DMEM_DEPTH (1 << `DMEM_AW)

`define CNT_W 64

`endif
